/* rtl/blob_sort_pkg.sv */
package blob_sort_pkg;

	localparam int addr_w = 18;
	localparam int data_w = 32;
	localparam int slot_w = 8;
	localparam int rank_w = 2;
	localparam int num_ranks = 3;

	typedef logic [addr_w-1:0] ptr_t;

	// order matches the mode switch codes
	typedef enum logic [1:0] {
		size_biggest  = 2'd0,
		size_smallest = 2'd1,
		y_highest     = 2'd2,
		y_lowest      = 2'd3
	} sort_mode_t;

	// one stored key, read as a size or as a centroid pair
	typedef union packed {
		logic [15:0] size;
		struct packed {
			logic [7:0] x;
			logic [7:0] y;
		} xy;
	} rank_key_u;

	// word offsets inside one blob record
	localparam ptr_t rec_words = 18'd3;
	localparam ptr_t slot_word = 18'd0;
	localparam ptr_t blob_word = 18'd1;

	function automatic logic size_mode(sort_mode_t m);
		return (m == size_biggest) || (m == size_smallest);
	endfunction

	// color slot sits in the low byte of word 0
	function automatic logic [slot_w-1:0] slot_field(logic [data_w-1:0] w);
		return w[slot_w-1:0];
	endfunction

	// word 1 is x, y, size from the top down
	function automatic rank_key_u blob_key(logic [data_w-1:0] w, sort_mode_t m);
		rank_key_u k;
		if (size_mode(m)) begin
			k.size = w[15:0];
		end else begin
			k.xy.x = w[31:24];
			k.xy.y = w[23:16];
		end
		return k;
	endfunction

endpackage

/* rtl/blob_fetch.sv */
`timescale 1ns/100ps

module blob_fetch #(
	parameter int num_slots = 6,
	parameter blob_sort_pkg::ptr_t base_addr = 18'd200000
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 run,
	input  blob_sort_pkg::sort_mode_t            mode,
	input  logic [15:0]                          blob_count,
	output logic                                 mem_req,
	output blob_sort_pkg::ptr_t                  mem_addr,
	input  logic                                 mem_ack,
	input  logic [blob_sort_pkg::data_w-1:0]     mem_rdata,
	output logic                                 fetch_done,
	output logic                                 cand_valid,
	output logic [blob_sort_pkg::slot_w-1:0]     cand_slot,
	output blob_sort_pkg::rank_key_u             cand_key,
	output blob_sort_pkg::ptr_t                  cand_ptr,
	input  logic                                 cand_take
);
	import blob_sort_pkg::*;

	localparam logic [1:0] f_next = 2'd0;
	localparam logic [1:0] f_slot = 2'd1;
	localparam logic [1:0] f_key = 2'd2;
	localparam logic [1:0] f_release = 2'd3;

	logic [1:0] state;
	logic [15:0] rec_cnt;
	ptr_t rec_addr;
	logic want_key;
	logic [slot_w-1:0] word_slot;
	logic slot_ok;

	assign word_slot = slot_field(mem_rdata);
	// slot 0 and slots past the table are not ranked
	assign slot_ok = (word_slot != '0) && (word_slot <= num_slots);

	always_ff @(posedge clk) begin
		if (!rst_n || !run) begin
			state <= f_next;
			mem_req <= 1'b0;
			rec_cnt <= '0;
			rec_addr <= base_addr;
			want_key <= 1'b0;
			fetch_done <= 1'b0;
			cand_valid <= 1'b0;
		end else begin
			if (cand_take) begin
				cand_valid <= 1'b0;
			end
			case (state)
				f_next: begin
					fetch_done <= (rec_cnt == blob_count) && !cand_valid;
					// a held candidate blocks the next record
					if (rec_cnt != blob_count && !mem_ack && (!cand_valid || cand_take)) begin
						mem_req <= 1'b1;
						mem_addr <= rec_addr + slot_word;
						state <= f_slot;
					end
				end
				f_slot: if (mem_ack) begin
					mem_req <= 1'b0;
					cand_slot <= word_slot;
					want_key <= slot_ok;
					if (!slot_ok) begin
						rec_addr <= rec_addr + rec_words;
						rec_cnt <= rec_cnt + 16'd1;
					end
					state <= f_release;
				end
				f_release: if (!mem_ack) begin
					if (want_key) begin
						mem_req <= 1'b1;
						mem_addr <= rec_addr + blob_word;
						state <= f_key;
					end else begin
						state <= f_next;
					end
				end
				default: if (mem_ack) begin
					mem_req <= 1'b0;
					cand_valid <= 1'b1;
					cand_key <= blob_key(mem_rdata, mode);
					cand_ptr <= rec_addr;
					rec_addr <= rec_addr + rec_words;
					rec_cnt <= rec_cnt + 16'd1;
					want_key <= 1'b0;
					state <= f_release;
				end
			endcase
		end
	end

endmodule

/* rtl/rank_key_table.sv */
`timescale 1ns/100ps

module rank_key_table #(
	parameter int num_slots = 6
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             clear,
	input  blob_sort_pkg::sort_mode_t        mode,
	input  logic [blob_sort_pkg::slot_w-1:0] cand_slot,
	input  blob_sort_pkg::rank_key_u         cand_key,
	input  logic                             ins_en,
	input  logic [blob_sort_pkg::slot_w-1:0] rd_slot,
	input  logic [blob_sort_pkg::rank_w-1:0] rd_rank,
	output logic [blob_sort_pkg::rank_w-1:0] ins_pos,
	output blob_sort_pkg::rank_key_u         rd_key,
	output logic                             rd_valid
);
	import blob_sort_pkg::*;

	rank_key_u key_q [1:num_slots][num_ranks];
	logic [num_ranks-1:0] vld_q [1:num_slots];
	logic cand_ok;
	logic rd_ok;

	// strict compare, equal keys never pass
	function automatic logic beats(rank_key_u cand, rank_key_u entry, sort_mode_t m);
		case (m)
			size_biggest: return cand.size > entry.size;
			size_smallest: return cand.size < entry.size;
			y_highest: return cand.xy.y > entry.xy.y;
			default: return cand.xy.y < entry.xy.y;
		endcase
	endfunction

	assign cand_ok = (cand_slot != '0) && (cand_slot <= num_slots);
	assign rd_ok = (rd_slot != '0) && (rd_slot <= num_slots) && (rd_rank < num_ranks);

	// best rank the candidate passes, num_ranks when none
	always_comb begin
		ins_pos = rank_w'(num_ranks);
		if (cand_ok) begin
			for (int r = num_ranks - 1; r >= 0; r--) begin
				if (!vld_q[cand_slot][r] || beats(cand_key, key_q[cand_slot][r], mode)) begin
					ins_pos = rank_w'(r);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			for (int s = 1; s <= num_slots; s++) begin
				vld_q[s] <= '0;
			end
		end else if (ins_en) begin
			for (int r = 1; r < num_ranks; r++) begin
				if (r > ins_pos) begin
					vld_q[cand_slot][r] <= vld_q[cand_slot][r-1];
				end
			end
			vld_q[cand_slot][ins_pos] <= 1'b1;
		end
	end

	// worse entries slide down, the last one drops out
	always_ff @(posedge clk) begin
		if (ins_en) begin
			for (int r = 1; r < num_ranks; r++) begin
				if (r > ins_pos) begin
					key_q[cand_slot][r] <= key_q[cand_slot][r-1];
				end
			end
			key_q[cand_slot][ins_pos] <= cand_key;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_ok && vld_q[rd_slot][rd_rank];
		end
	end

	always_ff @(posedge clk) begin
		rd_key <= rd_ok ? key_q[rd_slot][rd_rank] : '0;
	end

endmodule

/* rtl/rank_pointer_table.sv */
`timescale 1ns/100ps

module rank_pointer_table #(
	parameter int num_slots = 6
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             clear,
	input  logic [blob_sort_pkg::slot_w-1:0] cand_slot,
	input  blob_sort_pkg::ptr_t              cand_ptr,
	input  logic                             ins_en,
	input  logic [blob_sort_pkg::rank_w-1:0] ins_pos,
	input  logic [blob_sort_pkg::slot_w-1:0] rd_slot,
	input  logic [blob_sort_pkg::rank_w-1:0] rd_rank,
	output blob_sort_pkg::ptr_t              rd_ptr
);
	import blob_sort_pkg::*;

	ptr_t ptr_q [1:num_slots][num_ranks];
	logic rd_ok;

	assign rd_ok = (rd_slot != '0) && (rd_slot <= num_slots) && (rd_rank < num_ranks);

	// moves in lock step with the key table
	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			for (int s = 1; s <= num_slots; s++) begin
				for (int r = 0; r < num_ranks; r++) begin
					ptr_q[s][r] <= '0;
				end
			end
		end else if (ins_en) begin
			for (int r = 1; r < num_ranks; r++) begin
				if (r > ins_pos) begin
					ptr_q[cand_slot][r] <= ptr_q[cand_slot][r-1];
				end
			end
			ptr_q[cand_slot][ins_pos] <= cand_ptr;
		end
	end

	always_ff @(posedge clk) begin
		rd_ptr <= rd_ok ? ptr_q[rd_slot][rd_rank] : '0;
	end

endmodule

/* rtl/blob_sort_ctrl.sv */
`timescale 1ns/100ps

module blob_sort_ctrl (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             start,
	input  blob_sort_pkg::sort_mode_t        sort_mode,
	input  logic                             fetch_done,
	input  logic                             cand_valid,
	input  logic [blob_sort_pkg::rank_w-1:0] ins_pos,
	input  blob_sort_pkg::rank_key_u         rd_key,
	input  logic                             rd_valid_raw,
	output logic                             run,
	output blob_sort_pkg::sort_mode_t        mode_q,
	output logic                             clear,
	output logic                             ins_en,
	output logic                             cand_take,
	output logic                             done,
	output logic                             rd_valid,
	output logic [15:0]                      rd_size,
	output logic [7:0]                       rd_x,
	output logic [7:0]                       rd_y
);
	import blob_sort_pkg::*;

	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_clear = 3'd1;
	localparam logic [2:0] st_run = 3'd2;
	localparam logic [2:0] st_done = 3'd3;
	localparam logic [2:0] st_wait = 3'd4;

	logic [2:0] state;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			mode_q <= size_biggest;
		end else begin
			case (state)
				st_idle: if (start) begin
					mode_q <= sort_mode;
					state <= st_clear;
				end
				st_clear: state <= st_run;
				// start dropping early aborts the pass
				st_run: if (!start) begin
					state <= st_idle;
				end else if (fetch_done) begin
					state <= st_done;
				end
				st_done: state <= start ? st_wait : st_idle;
				st_wait: if (!start) begin
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign run = (state == st_run);
	assign clear = (state == st_clear);
	assign done = (state == st_done) || (state == st_wait);
	// every candidate is consumed the cycle it shows up
	assign cand_take = run && cand_valid;
	assign ins_en = cand_take && (ins_pos < num_ranks);

	// fields that the mode did not store read back as zero
	assign rd_valid = rd_valid_raw;
	assign rd_size = (rd_valid_raw && size_mode(mode_q)) ? rd_key.size : '0;
	assign rd_x = (rd_valid_raw && !size_mode(mode_q)) ? rd_key.xy.x : '0;
	assign rd_y = (rd_valid_raw && !size_mode(mode_q)) ? rd_key.xy.y : '0;

endmodule

/* rtl/blob_sorting.sv */
`timescale 1ns/100ps

module blob_sorting #(
	parameter int num_slots = 6,
	parameter blob_sort_pkg::ptr_t base_addr = 18'd200000
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             start,
	input  blob_sort_pkg::sort_mode_t        sort_mode,
	input  logic [15:0]                      blob_count,
	output logic                             done,
	output logic                             mem_req,
	output blob_sort_pkg::ptr_t              mem_addr,
	input  logic                             mem_ack,
	input  logic [blob_sort_pkg::data_w-1:0] mem_rdata,
	input  logic [blob_sort_pkg::slot_w-1:0] rd_slot,
	input  logic [blob_sort_pkg::rank_w-1:0] rd_rank,
	output logic                             rd_valid,
	output logic [15:0]                      rd_size,
	output logic [7:0]                       rd_x,
	output logic [7:0]                       rd_y,
	output blob_sort_pkg::ptr_t              rd_ptr
);
	import blob_sort_pkg::*;

	logic run;
	logic clear;
	logic fetch_done;
	logic cand_valid;
	logic cand_take;
	logic ins_en;
	logic rd_valid_raw;
	logic [slot_w-1:0] cand_slot;
	logic [rank_w-1:0] ins_pos;
	sort_mode_t mode_q;
	rank_key_u cand_key;
	rank_key_u rd_key;
	ptr_t cand_ptr;

	blob_fetch #(
		.num_slots (num_slots),
		.base_addr (base_addr)
	) u_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.run        (run),
		.mode       (mode_q),
		.blob_count (blob_count),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_ack    (mem_ack),
		.mem_rdata  (mem_rdata),
		.fetch_done (fetch_done),
		.cand_valid (cand_valid),
		.cand_slot  (cand_slot),
		.cand_key   (cand_key),
		.cand_ptr   (cand_ptr),
		.cand_take  (cand_take)
	);

	rank_key_table #(
		.num_slots (num_slots)
	) u_keys (
		.clk       (clk),
		.rst_n     (rst_n),
		.clear     (clear),
		.mode      (mode_q),
		.cand_slot (cand_slot),
		.cand_key  (cand_key),
		.ins_en    (ins_en),
		.rd_slot   (rd_slot),
		.rd_rank   (rd_rank),
		.ins_pos   (ins_pos),
		.rd_key    (rd_key),
		.rd_valid  (rd_valid_raw)
	);

	rank_pointer_table #(
		.num_slots (num_slots)
	) u_ptrs (
		.clk       (clk),
		.rst_n     (rst_n),
		.clear     (clear),
		.cand_slot (cand_slot),
		.cand_ptr  (cand_ptr),
		.ins_en    (ins_en),
		.ins_pos   (ins_pos),
		.rd_slot   (rd_slot),
		.rd_rank   (rd_rank),
		.rd_ptr    (rd_ptr)
	);

	blob_sort_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.sort_mode    (sort_mode),
		.fetch_done   (fetch_done),
		.cand_valid   (cand_valid),
		.ins_pos      (ins_pos),
		.rd_key       (rd_key),
		.rd_valid_raw (rd_valid_raw),
		.run          (run),
		.mode_q       (mode_q),
		.clear        (clear),
		.ins_en       (ins_en),
		.cand_take    (cand_take),
		.done         (done),
		.rd_valid     (rd_valid),
		.rd_size      (rd_size),
		.rd_x         (rd_x),
		.rd_y         (rd_y)
	);

endmodule

/* tests/blob_sorting_chk.sv */
`timescale 1ns/100ps

module blob_sorting_chk (
	input logic                clk,
	input logic                rst_n,
	input logic                start,
	input logic                done,
	input logic                mem_req,
	input logic                mem_ack,
	input blob_sort_pkg::ptr_t mem_addr
);

	int fail_cnt = 0;

	// address has to hold for the whole request
	addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req && $past(mem_req) |-> $stable(mem_addr))
		else begin
			$error("mem_addr changed while mem_req was held high");
			fail_cnt++;
		end

	// a new request only after the previous ack is gone
	req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_req) |-> !$past(mem_ack))
		else begin
			$error("mem_req rose while mem_ack was still high");
			fail_cnt++;
		end

	done_hold: assert property (@(posedge clk) disable iff (!rst_n)
		done && start |=> done)
		else begin
			$error("done fell while start was still high");
			fail_cnt++;
		end

	done_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(start) |=> !done)
		else begin
			$error("done did not fall one cycle after start fell");
			fail_cnt++;
		end

endmodule

/* tests/blob_sorting_mon.sv */
`timescale 1ns/100ps

module blob_sorting_mon #(
	parameter int num_slots = 6
) (
	input  logic                                               clk,
	input  logic                                               done,
	input  blob_sort_pkg::sort_mode_t                          mode,
	input  logic [(num_slots+2)*3-1:0]                         exp_valid,
	input  logic [(num_slots+2)*3-1:0][15:0]                   exp_key,
	input  logic [(num_slots+2)*3-1:0][blob_sort_pkg::addr_w-1:0] exp_ptr,
	input  logic                                               rd_valid,
	input  logic [15:0]                                        rd_size,
	input  logic [7:0]                                         rd_x,
	input  logic [7:0]                                         rd_y,
	input  blob_sort_pkg::ptr_t                                rd_ptr,
	output logic [blob_sort_pkg::slot_w-1:0]                   rd_slot,
	output logic [blob_sort_pkg::rank_w-1:0]                   rd_rank,
	output int                                                 checks_done,
	output int                                                 err_cnt
);
	import blob_sort_pkg::*;

	logic done_seen;

	task automatic compare(input string name, input int s, input int r,
			input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s slot %0d rank %0d: got %h, expected %h",
				name, s, r, got, exp);
			err_cnt++;
		end
	endtask

	// slot 0 and the first slot past the table are read too, both stay empty
	task automatic read_tables();
		int idx;
		logic [15:0] key;
		logic by_size;
		by_size = (mode == size_biggest) || (mode == size_smallest);
		for (int s = 0; s <= num_slots + 1; s++) begin
			for (int r = 0; r < 3; r++) begin
				rd_slot = s[slot_w-1:0];
				rd_rank = r[rank_w-1:0];
				@(negedge clk);
				idx = s * 3 + r;
				key = exp_valid[idx] ? exp_key[idx] : 16'h0;
				compare("rd_valid", s, r, rd_valid, exp_valid[idx]);
				compare("rd_size", s, r, rd_size, by_size ? key : 16'h0);
				compare("rd_x", s, r, rd_x, by_size ? 8'h0 : key[15:8]);
				compare("rd_y", s, r, rd_y, by_size ? 8'h0 : key[7:0]);
				if (exp_valid[idx]) begin
					compare("rd_ptr", s, r, rd_ptr, exp_ptr[idx]);
				end
			end
		end
	endtask

	initial begin
		rd_slot = '0;
		rd_rank = '0;
		checks_done = 0;
		err_cnt = 0;
		done_seen = 1'b0;
		forever begin
			@(negedge clk);
			if (done === 1'b1 && !done_seen) begin
				done_seen = 1'b1;
				read_tables();
				checks_done++;
			end else if (done !== 1'b1) begin
				done_seen = 1'b0;
			end
		end
	end

endmodule

/* tests/blob_sorting_tb.sv */
`timescale 1ns/100ps

module blob_sorting_tb;
	import blob_sort_pkg::*;

	localparam int num_slots = 6;
	localparam ptr_t base_addr = 18'd200000;
	localparam int n_entries = (num_slots + 2) * 3;
	localparam int mem_words = 128;
	localparam int done_limit = 5000;
	localparam int check_limit = 200;

	logic clk;
	logic rst_n;
	logic start;
	sort_mode_t sort_mode;
	logic [15:0] blob_count;
	logic done;
	logic mem_req;
	ptr_t mem_addr;
	logic mem_ack;
	logic [31:0] mem_rdata;
	logic [slot_w-1:0] rd_slot;
	logic [rank_w-1:0] rd_rank;
	logic rd_valid;
	logic [15:0] rd_size;
	logic [7:0] rd_x;
	logic [7:0] rd_y;
	ptr_t rd_ptr;
	int mon_checks;
	int mon_errs;
	int chk_errs;

	logic [n_entries-1:0] exp_valid;
	logic [n_entries-1:0][15:0] exp_key;
	logic [n_entries-1:0][addr_w-1:0] exp_ptr;

	logic [31:0] mem [0:mem_words-1];
	logic [31:0] lcg_state = 32'h7b6;
	int ack_delay;
	int mem_errs;
	bit timed_out;
	int tests_run;
	int tests_failed;

	blob_sorting #(
		.num_slots (num_slots),
		.base_addr (base_addr)
	) blob_sorting_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.sort_mode  (sort_mode),
		.blob_count (blob_count),
		.done       (done),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_ack    (mem_ack),
		.mem_rdata  (mem_rdata),
		.rd_slot    (rd_slot),
		.rd_rank    (rd_rank),
		.rd_valid   (rd_valid),
		.rd_size    (rd_size),
		.rd_x       (rd_x),
		.rd_y       (rd_y),
		.rd_ptr     (rd_ptr)
	);

	blob_sorting_mon #(
		.num_slots (num_slots)
	) mon_i (
		.clk         (clk),
		.done        (done),
		.mode        (sort_mode),
		.exp_valid   (exp_valid),
		.exp_key     (exp_key),
		.exp_ptr     (exp_ptr),
		.rd_valid    (rd_valid),
		.rd_size     (rd_size),
		.rd_x        (rd_x),
		.rd_y        (rd_y),
		.rd_ptr      (rd_ptr),
		.rd_slot     (rd_slot),
		.rd_rank     (rd_rank),
		.checks_done (mon_checks),
		.err_cnt     (mon_errs)
	);

	bind blob_sorting blob_sorting_chk chk_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.done     (done),
		.mem_req  (mem_req),
		.mem_ack  (mem_ack),
		.mem_addr (mem_addr)
	);

	assign chk_errs = blob_sorting_i.chk_i.fail_cnt;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [15:0] rand16();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];
	endfunction

	function automatic logic [31:0] read_word(input ptr_t addr);
		int unsigned offset;
		offset = addr - base_addr;
		if (addr < base_addr || offset >= mem_words) begin
			$display("memory read outside the record area at address %h", addr);
			mem_errs++;
			return 32'h0;
		end
		return mem[offset];
	endfunction

	// memory answers each request after 0 to 3 cycles
	always @(negedge clk) begin
		if (mem_req === 1'b1 && !mem_ack) begin
			if (ack_delay == 0) begin
				mem_rdata = read_word(mem_addr);
				mem_ack = 1'b1;
			end else begin
				ack_delay--;
			end
		end else if (mem_req === 1'b0 && mem_ack) begin
			mem_ack = 1'b0;
			ack_delay = rand16() % 4;
		end
	end

	function automatic logic key_better(input sort_mode_t mode, input logic [15:0] a,
			input logic [15:0] b);
		case (mode)
			size_biggest: return a > b;
			size_smallest: return a < b;
			y_highest: return a[7:0] > b[7:0];
			default: return a[7:0] < b[7:0];
		endcase
	endfunction

	// top three per slot, records taken in arrival order
	function automatic void rank_reference(input sort_mode_t mode, input int count);
		logic [31:0] w0;
		logic [31:0] w1;
		logic [15:0] key;
		int i;
		int r;
		int slot;
		int b;
		int pos;
		exp_valid = '0;
		exp_key = '0;
		exp_ptr = '0;
		for (i = 0; i < count; i++) begin
			w0 = mem[3*i];
			w1 = mem[3*i+1];
			slot = w0[7:0];
			if (slot >= 1 && slot <= num_slots) begin
				key = (mode == size_biggest || mode == size_smallest) ? w1[15:0] : w1[31:16];
				b = slot * 3;
				pos = 0;
				while (pos < 3 && exp_valid[b+pos] && !key_better(mode, key, exp_key[b+pos])) begin
					pos++;
				end
				for (r = 2; r > pos; r--) begin
					exp_valid[b+r] = exp_valid[b+r-1];
					exp_key[b+r] = exp_key[b+r-1];
					exp_ptr[b+r] = exp_ptr[b+r-1];
				end
				if (pos < 3) begin
					exp_valid[b+pos] = 1'b1;
					exp_key[b+pos] = key;
					exp_ptr[b+pos] = base_addr + 3 * i;
				end
			end
		end
	endfunction

	task automatic fill_pattern();
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = 32'h5a000000 ^ (base_addr + i);
		end
	endtask

	// slots 0 to 8, so slot 0 and slots past the table show up too
	task automatic fill_random(input int count);
		logic [15:0] r_hi;
		logic [15:0] r_lo;
		for (int i = 0; i < count; i++) begin
			r_hi = rand16();
			r_lo = rand16();
			mem[3*i] = {r_hi, r_lo[15:8], 8'(r_lo % 9)};
			r_hi = rand16();
			r_lo = rand16();
			mem[3*i+1] = {r_hi, r_lo};
		end
	endtask

	task automatic set_record(input int i, input logic [7:0] slot, input logic [7:0] x,
			input logic [7:0] y, input logic [15:0] size);
		mem[3*i] = {24'hc3c3c3, slot};
		mem[3*i+1] = {x, y, size};
	endtask

	task automatic wait_done(input logic level, input string name);
		int cycles;
		cycles = 0;
		while (!timed_out && done !== level && cycles < done_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!timed_out && done !== level) begin
			$display("timeout: done did not go to %0d in test %s", level, name);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_checked(input int target, input string name);
		int cycles;
		cycles = 0;
		while (!timed_out && mon_checks != target && cycles < check_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!timed_out && mon_checks != target) begin
			$display("timeout: the table readout did not finish in test %s", name);
			timed_out = 1'b1;
		end
	endtask

	task automatic run_test(input string name, input sort_mode_t mode, input int count);
		int errs_before;
		int checks_before;
		int errs;
		if (timed_out) begin
			return;
		end
		errs_before = mon_errs + mem_errs + chk_errs;
		checks_before = mon_checks;
		rank_reference(mode, count);
		@(negedge clk);
		sort_mode = mode;
		blob_count = 16'(count);
		start = 1'b1;
		wait_done(1'b1, name);
		wait_checked(checks_before + 1, name);
		tests_run++;
		errs = mon_errs + mem_errs + chk_errs - errs_before;
		if (timed_out || errs != 0) begin
			tests_failed++;
		end
		$display("test %0d %s: %s, %0d errors", tests_run, name,
			(timed_out || errs != 0) ? "failed" : "passed", errs);
		start = 1'b0;
		wait_done(1'b0, name);
	endtask

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		sort_mode = size_biggest;
		blob_count = '0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		mem_errs = 0;
		timed_out = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		ack_delay = rand16() % 4;
		fill_pattern();
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		// same random memory ranked four ways
		fill_random(40);
		run_test("size biggest", size_biggest, 40);
		run_test("size smallest", size_smallest, 40);
		run_test("y highest", y_highest, 40);
		run_test("y lowest", y_lowest, 40);

		// skipped slots, and slots with fewer than three blobs
		fill_pattern();
		set_record(0, 8'd0, 8'd1, 8'd1, 16'd900);
		set_record(1, 8'd2, 8'd2, 8'd2, 16'd100);
		set_record(2, 8'd7, 8'd3, 8'd3, 16'd800);
		set_record(3, 8'd2, 8'd4, 8'd4, 16'd300);
		set_record(4, 8'd255, 8'd5, 8'd5, 16'd700);
		set_record(5, 8'd5, 8'd6, 8'd6, 16'd50);
		set_record(6, 8'd0, 8'd7, 8'd7, 16'd600);
		run_test("skipped records", size_biggest, 7);

		// equal keys keep arrival order
		fill_pattern();
		set_record(0, 8'd3, 8'd1, 8'd10, 16'd500);
		set_record(1, 8'd3, 8'd2, 8'd10, 16'd500);
		set_record(2, 8'd4, 8'd3, 8'd40, 16'd9);
		set_record(3, 8'd3, 8'd4, 8'd20, 16'd700);
		set_record(4, 8'd4, 8'd5, 8'd40, 16'd9);
		set_record(5, 8'd3, 8'd6, 8'd10, 16'd500);
		set_record(6, 8'd4, 8'd7, 8'd40, 16'd9);
		set_record(7, 8'd3, 8'd8, 8'd5, 16'd500);
		run_test("ties size biggest", size_biggest, 8);
		run_test("ties y lowest", y_lowest, 8);

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			mon_errs + mem_errs + chk_errs);
		if (tests_failed == 0 && !timed_out && chk_errs == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* sim.f */
rtl/blob_sort_pkg.sv
rtl/blob_fetch.sv
rtl/rank_key_table.sv
rtl/rank_pointer_table.sv
rtl/blob_sort_ctrl.sv
rtl/blob_sorting.sv
tests/blob_sorting_chk.sv
tests/blob_sorting_mon.sv
tests/blob_sorting_tb.sv

/* Bender.yml */
package:
  name: blob_sorting

sources:
  - rtl/blob_sort_pkg.sv
  - rtl/blob_fetch.sv
  - rtl/rank_key_table.sv
  - rtl/rank_pointer_table.sv
  - rtl/blob_sort_ctrl.sv
  - rtl/blob_sorting.sv
  - target: test
    files:
      - tests/blob_sorting_chk.sv
      - tests/blob_sorting_mon.sv
      - tests/blob_sorting_tb.sv
